// File: rtl/l2_cache_defines.svh
`ifndef L2_CACHE_DEFINES_SVH
`define L2_CACHE_DEFINES_SVH

// msb of the 64-bit ddr word address
`define L2_ADDRBITS 24

// geometry
`define L2_SETS      128
`define L2_WAYS      4
`define L2_LINEWORDS 8

`define L2_SETBITS  7
`define L2_WAYBITS  2
`define L2_WORDBITS 3
`define L2_TAGBITS  (`L2_ADDRBITS + 1 - `L2_SETBITS - `L2_WORDBITS)

// rom window in cpu word addresses, bytes 0xC0000-0xFFFFF
`define L2_ROM_BASE 30'h30000
`define L2_ROM_TOP  30'h3FFFF

`endif

// File: rtl/l2_cache_pkg.sv
`include "l2_cache_defines.svh"

package l2_cache_pkg;

	typedef enum logic [1:0] {
		read_ram,
		read_zero,   // above ram, answered without ddr
		write_ram
	} req_kind_t;

	typedef struct packed {
		req_kind_t             kind;
		logic [`L2_ADDRBITS:0] addr;   // 64-bit word address
		logic                  hi;     // upper cpu word of addr
		logic [31:0]           data;
		logic [3:0]            be;
		logic [3:0]            burst;
		logic                  force_fetch;
	} cpu_req_t;

	// one ddr beat, raw or as two cpu words
	typedef union packed {
		logic [63:0] raw;
		struct packed {
			logic [31:0] hi;
			logic [31:0] lo;
		} half;
	} ddr_word_u;

endpackage

// File: rtl/l2_cache_if.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

interface cache_req_if;
	logic                   valid;    // one-cycle pulse
	l2_cache_pkg::cpu_req_t req;
	logic                   accept;   // controller idle

	modport producer (output valid, output req, input accept);
	modport controller (input valid, input req, output accept);
endinterface

interface ddr_cmd_if;
	logic                  rd;
	logic                  we;
	logic [`L2_ADDRBITS:0] addr;
	logic [63:0]           din;
	logic [7:0]            be;
	logic [7:0]            burstcnt;
	logic                  issue_ready;
	logic [63:0]           rdata;
	logic                  rvalid;

	modport controller (
		output rd, we, addr, din, be, burstcnt,
		input  issue_ready, rdata, rvalid
	);

	modport port (
		input  rd, we, addr, din, be, burstcnt,
		output issue_ready, rdata, rvalid
	);
endinterface

// File: rtl/cpu_req_decode.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

module cpu_req_decode (
	input  logic        CLK,
	input  logic        rst,
	input  logic [29:0] CPU_ADDR,
	input  logic [31:0] CPU_DIN,
	input  logic [3:0]  CPU_BE,
	input  logic [3:0]  CPU_BURSTCNT,
	input  logic        CPU_RD,
	input  logic        CPU_WE,
	input  logic        DISABLE,
	cache_req_if.producer req
);
	import l2_cache_pkg::*;

	logic     ram_rgn;
	logic     rom_rgn;
	logic     take;
	cpu_req_t nxt;

	assign ram_rgn = ~|CPU_ADDR[29:`L2_ADDRBITS+2];
	assign rom_rgn = (CPU_ADDR >= `L2_ROM_BASE) && (CPU_ADDR <= `L2_ROM_TOP);

	// rom writes and writes above ram never leave here
	assign take = req.accept && !req.valid &&
		(CPU_RD || (CPU_WE && ram_rgn && !rom_rgn));

	always_comb begin
		nxt.kind        = CPU_RD ? (ram_rgn ? read_ram : read_zero) : write_ram;
		nxt.addr        = CPU_ADDR[`L2_ADDRBITS+1:1];
		nxt.hi          = CPU_ADDR[0];
		nxt.data        = CPU_DIN;
		nxt.be          = CPU_BE;
		nxt.burst       = CPU_BURSTCNT;
		nxt.force_fetch = DISABLE;
	end

	always_ff @(posedge CLK) begin
		if (rst)
			req.valid <= 1'b0;
		else
			req.valid <= take;
	end

	always_ff @(posedge CLK) begin
		if (take)
			req.req <= nxt;
	end

	// controller must still be idle when the pulse lands
	assert property (@(posedge CLK) disable iff (rst) req.valid |-> req.accept)
		else $error("request valid while controller not accepting");

endmodule

// File: rtl/cache_store.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

module cache_store (
	input  logic                                CLK,
	input  logic                                rst,
	input  logic [`L2_SETBITS-1:0]              set,
	input  logic [`L2_TAGBITS-1:0]              tag,
	input  logic                                lookup,
	input  logic                                fill_we,
	input  l2_cache_pkg::ddr_word_u             fill_word,
	input  logic [`L2_WAYBITS-1:0]              fill_way,
	input  logic                                write_we,
	input  logic [7:0]                          write_be,
	input  logic [63:0]                         write_data,
	input  logic                                commit,
	input  logic                                touch,
	input  logic [`L2_WAYBITS-1:0]              touch_way,
	input  logic [`L2_SETBITS+`L2_WORDBITS:0]   rd_addr,
	input  logic                                inval_set,
	output logic                                hit,
	output logic [`L2_WAYBITS-1:0]              hit_way,
	output logic [`L2_WAYBITS-1:0]              victim_way,
	output logic [31:0]                         rd_data
);
	import l2_cache_pkg::*;

	logic [`L2_TAGBITS-1:0] tags [`L2_WAYS][`L2_SETS];
	logic [`L2_WAYS-1:0]    valid [`L2_SETS];
	logic [`L2_WAYBITS-1:0] age [`L2_SETS][`L2_WAYS];
	ddr_word_u              data [`L2_WAYS][`L2_SETS*`L2_LINEWORDS];

	logic [`L2_WAYS-1:0]                  hit_vec;
	logic [`L2_WAYBITS-1:0]               touch_age;
	logic [`L2_SETBITS+`L2_WORDBITS-1:0]  line_idx;
	ddr_word_u                            rd_word;
	logic                                 rd_hi;

	assign line_idx  = rd_addr[`L2_SETBITS+`L2_WORDBITS:1];
	assign touch_age = age[set][touch_way];

	always_comb begin
		hit_vec    = '0;
		hit_way    = '0;
		victim_way = '0;
		for (int w = 0; w < `L2_WAYS; w++) begin
			hit_vec[w] = valid[set][w] && (tags[w][set] == tag);
			if (hit_vec[w])
				hit_way = `L2_WAYBITS'(w);
			if (age[set][w] == '1)   // oldest way
				victim_way = `L2_WAYBITS'(w);
		end
	end
	assign hit = |hit_vec;

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int s = 0; s < `L2_SETS; s++)
				valid[s] <= '0;
		end else if (inval_set)
			valid[set] <= '0;
		else if (fill_we)
			valid[set][fill_way] <= 1'b0;   // line unusable until commit
		else if (commit)
			valid[set][fill_way] <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (commit)
			tags[fill_way][set] <= tag;
	end

	always_ff @(posedge CLK) begin
		for (int w = 0; w < `L2_WAYS; w++) begin
			if (inval_set)
				age[set][w] <= `L2_WAYBITS'(w);
			else if (touch) begin
				if (w == touch_way)
					age[set][w] <= '0;
				else if (age[set][w] < touch_age)
					age[set][w] <= age[set][w] + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fill_we)
			data[fill_way][line_idx] <= fill_word;
		else if (write_we) begin
			for (int b = 0; b < 8; b++)
				if (write_be[b])
					data[hit_way][line_idx].raw[b*8 +: 8] <= write_data[b*8 +: 8];
		end
	end

	always_ff @(posedge CLK) begin
		if (lookup)
			rd_word <= data[hit_way][line_idx];
	end

	always_ff @(posedge CLK) begin
		if (rst)
			rd_hi <= 1'b0;
		else if (lookup)
			rd_hi <= rd_addr[0];
	end

	assign rd_data = rd_hi ? rd_word.half.hi : rd_word.half.lo;

	// fill policy must never leave the same tag in two ways
	assert property (@(posedge CLK) disable iff (rst) (lookup || write_we) |-> $onehot0(hit_vec))
		else $error("more than one way hit in set %0d", set);

endmodule

// File: rtl/ddram_port.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

module ddram_port (
	input  logic                  CLK,
	input  logic                  rst,
	ddr_cmd_if.port               cmd,
	input  logic [63:0]           DDRAM_DOUT,
	input  logic                  DDRAM_DOUT_READY,
	input  logic                  DDRAM_BUSY,
	output logic [`L2_ADDRBITS:0] DDRAM_ADDR,
	output logic [63:0]           DDRAM_DIN,
	output logic [7:0]            DDRAM_BE,
	output logic [7:0]            DDRAM_BURSTCNT,
	output logic                  DDRAM_RD,
	output logic                  DDRAM_WE
);
	logic load;

	// a strobe stays up until the ddr side drops busy
	assign load = !DDRAM_BUSY || !(DDRAM_RD || DDRAM_WE);
	assign cmd.issue_ready = !DDRAM_BUSY;

	always_ff @(posedge CLK) begin
		if (rst) begin
			DDRAM_RD <= 1'b0;
			DDRAM_WE <= 1'b0;
		end else if (load) begin
			DDRAM_RD <= cmd.rd;
			DDRAM_WE <= cmd.we;
		end
	end

	always_ff @(posedge CLK) begin
		if (load && (cmd.rd || cmd.we)) begin
			DDRAM_ADDR     <= cmd.addr;
			DDRAM_DIN      <= cmd.din;
			DDRAM_BE       <= cmd.be;
			DDRAM_BURSTCNT <= cmd.burstcnt;
		end
	end

	always_ff @(posedge CLK) begin
		cmd.rdata <= DDRAM_DOUT;
		if (rst)
			cmd.rvalid <= 1'b0;
		else
			cmd.rvalid <= DDRAM_DOUT_READY;
	end

	assert property (@(posedge CLK) disable iff (rst) !(DDRAM_RD && DDRAM_WE))
		else $error("ddr rd and we asserted together");

endmodule

// File: rtl/l2_cache.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

module l2_cache (
	input  logic                               CLK,
	input  logic                               rst,
	cache_req_if.controller                    req,
	ddr_cmd_if.controller                      cmd,
	output logic [`L2_SETBITS-1:0]             set,
	output logic [`L2_TAGBITS-1:0]             tag,
	output logic                               lookup,
	output logic                               fill_we,
	output l2_cache_pkg::ddr_word_u            fill_word,
	output logic [`L2_WAYBITS-1:0]             fill_way,
	output logic                               write_we,
	output logic [7:0]                         write_be,
	output logic [63:0]                        write_data,
	output logic                               commit,
	output logic                               touch,
	output logic [`L2_WAYBITS-1:0]             touch_way,
	output logic [`L2_SETBITS+`L2_WORDBITS:0]  rd_addr,
	output logic                               inval_set,
	input  logic                               hit,
	input  logic [`L2_WAYBITS-1:0]             hit_way,
	input  logic [`L2_WAYBITS-1:0]             victim_way,
	input  logic [31:0]                        rd_data,
	output logic [31:0]                        CPU_DOUT,
	output logic                               CPU_DOUT_READY,
	output logic                               CPU_BUSY
);
	import l2_cache_pkg::*;

	localparam logic [2:0] st_init    = 3'd0;
	localparam logic [2:0] st_idle    = 3'd1;
	localparam logic [2:0] st_lookup  = 3'd2;
	localparam logic [2:0] st_issue   = 3'd3;
	localparam logic [2:0] st_fill    = 3'd4;
	localparam logic [2:0] st_commit  = 3'd5;
	localparam logic [2:0] st_readout = 3'd6;
	localparam logic [2:0] st_write   = 3'd7;

	logic [2:0]              state;
	cpu_req_t                cur;
	cpu_req_t                cur_next;
	logic                    last_word;
	logic                    word_done;
	logic [`L2_SETBITS-1:0]  cur_set;
	logic [`L2_SETBITS-1:0]  sweep_set;
	logic [`L2_WORDBITS-1:0] beat;
	logic                    zero_out;
	ddr_word_u               wr_word;

	// request after one burst word, halves alternate
	always_comb begin
		cur_next       = cur;
		cur_next.hi    = ~cur.hi;
		cur_next.addr  = cur.addr + {{`L2_ADDRBITS{1'b0}}, cur.hi};
		cur_next.burst = cur.burst - 4'd1;
	end
	assign last_word = cur.burst <= 4'd1;
	assign word_done = (lookup && hit && !cur.force_fetch) || (state == st_readout);

	assign cur_set   = cur.addr[`L2_SETBITS+`L2_WORDBITS-1:`L2_WORDBITS];
	assign set       = (state == st_init) ? sweep_set : cur_set;
	assign tag       = cur.addr[`L2_ADDRBITS:`L2_SETBITS+`L2_WORDBITS];
	assign rd_addr   = {cur_set, (state == st_fill) ? beat : cur.addr[`L2_WORDBITS-1:0], cur.hi};
	assign lookup    = state == st_lookup;
	assign inval_set = state == st_init;
	assign commit    = state == st_commit;
	assign touch     = lookup && hit && !cur.force_fetch;
	assign touch_way = hit_way;

	assign fill_we       = (state == st_fill) && cmd.rvalid;
	assign fill_word.raw = cmd.rdata;

	// cpu word goes out on both halves, be picks the lane
	always_comb begin
		wr_word.half.hi = cur.data;
		wr_word.half.lo = cur.data;
	end
	assign write_data = wr_word.raw;
	assign write_be   = cur.hi ? {cur.be, 4'h0} : {4'h0, cur.be};
	assign write_we   = (state == st_write) && hit && cmd.issue_ready;  // update in place only

	assign cmd.rd       = (state == st_issue) && cmd.issue_ready;
	assign cmd.we       = (state == st_write) && cmd.issue_ready;
	assign cmd.addr     = (state == st_issue) ?
		{cur.addr[`L2_ADDRBITS:`L2_WORDBITS], {`L2_WORDBITS{1'b0}}} : cur.addr;
	assign cmd.din      = wr_word.raw;
	assign cmd.be       = write_be;
	assign cmd.burstcnt = (state == st_issue) ? 8'(`L2_LINEWORDS) : 8'd1;

	assign req.accept = state == st_idle;
	assign CPU_BUSY   = (state != st_idle) || req.valid || !cmd.issue_ready;
	assign CPU_DOUT   = zero_out ? 32'h0 : rd_data;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state          <= st_init;
			sweep_set      <= '0;
			beat           <= '0;
			CPU_DOUT_READY <= 1'b0;
		end else begin
			CPU_DOUT_READY <= 1'b0;
			case (state)
				st_init: begin
					sweep_set <= sweep_set + 1'b1;
					if (sweep_set == `L2_SETBITS'(`L2_SETS - 1))
						state <= st_idle;
				end
				st_idle: begin
					if (req.valid) begin
						case (req.req.kind)
							read_zero: state <= st_readout;
							write_ram: state <= st_write;
							default:   state <= st_lookup;
						endcase
					end
				end
				st_lookup: begin
					if (hit && !cur.force_fetch) begin
						CPU_DOUT_READY <= 1'b1;
						if (last_word)
							state <= st_idle;
					end else
						state <= st_issue;
				end
				st_issue: begin
					if (cmd.issue_ready) begin
						beat  <= '0;
						state <= st_fill;
					end
				end
				st_fill: begin
					if (cmd.rvalid) begin
						beat <= beat + 1'b1;
						if (beat == '1)
							state <= st_commit;
					end
				end
				st_commit: state <= st_lookup;   // re-run as a hit
				st_readout: begin
					CPU_DOUT_READY <= 1'b1;
					if (last_word)
						state <= st_idle;
				end
				st_write: begin
					if (cmd.issue_ready)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if ((state == st_idle) && req.valid)
			cur <= req.req;
		else if (word_done)
			cur <= cur_next;
		else if (commit)
			cur.force_fetch <= 1'b0;

		// forced refetch reuses the matching way
		if (lookup) begin
			fill_way <= hit ? hit_way : victim_way;
			zero_out <= 1'b0;
		end else if (state == st_readout)
			zero_out <= 1'b1;
	end

endmodule

// File: rtl/l2_subsys_top.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

module l2_subsys_top (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic                  DISABLE,
	input  logic [29:0]           CPU_ADDR,
	input  logic [31:0]           CPU_DIN,
	output logic [31:0]           CPU_DOUT,
	output logic                  CPU_DOUT_READY,
	input  logic [3:0]            CPU_BE,
	input  logic [3:0]            CPU_BURSTCNT,
	output logic                  CPU_BUSY,
	input  logic                  CPU_RD,
	input  logic                  CPU_WE,
	output logic [`L2_ADDRBITS:0] DDRAM_ADDR,
	output logic [63:0]           DDRAM_DIN,
	input  logic [63:0]           DDRAM_DOUT,
	input  logic                  DDRAM_DOUT_READY,
	output logic [7:0]            DDRAM_BE,
	output logic [7:0]            DDRAM_BURSTCNT,
	input  logic                  DDRAM_BUSY,
	output logic                  DDRAM_RD,
	output logic                  DDRAM_WE
);
	logic [`L2_SETBITS-1:0]             set;
	logic [`L2_TAGBITS-1:0]             tag;
	logic                               lookup;
	logic                               fill_we;
	l2_cache_pkg::ddr_word_u            fill_word;
	logic [`L2_WAYBITS-1:0]             fill_way;
	logic                               write_we;
	logic [7:0]                         write_be;
	logic [63:0]                        write_data;
	logic                               commit;
	logic                               touch;
	logic [`L2_WAYBITS-1:0]             touch_way;
	logic [`L2_SETBITS+`L2_WORDBITS:0]  rd_addr;
	logic                               inval_set;
	logic                               hit;
	logic [`L2_WAYBITS-1:0]             hit_way;
	logic [`L2_WAYBITS-1:0]             victim_way;
	logic [31:0]                        rd_data;

	cache_req_if u_req_if ();
	ddr_cmd_if   u_cmd_if ();

	cpu_req_decode u_cpu_req_decode (
		.CLK(CLK), .rst(rst),
		.CPU_ADDR(CPU_ADDR), .CPU_DIN(CPU_DIN), .CPU_BE(CPU_BE),
		.CPU_BURSTCNT(CPU_BURSTCNT), .CPU_RD(CPU_RD), .CPU_WE(CPU_WE),
		.DISABLE(DISABLE), .req(u_req_if)
	);

	l2_cache u_l2_cache (
		.CLK(CLK), .rst(rst), .req(u_req_if), .cmd(u_cmd_if),
		.set(set), .tag(tag), .lookup(lookup),
		.fill_we(fill_we), .fill_word(fill_word), .fill_way(fill_way),
		.write_we(write_we), .write_be(write_be), .write_data(write_data),
		.commit(commit), .touch(touch), .touch_way(touch_way),
		.rd_addr(rd_addr), .inval_set(inval_set),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way), .rd_data(rd_data),
		.CPU_DOUT(CPU_DOUT), .CPU_DOUT_READY(CPU_DOUT_READY), .CPU_BUSY(CPU_BUSY)
	);

	cache_store u_cache_store (
		.CLK(CLK), .rst(rst),
		.set(set), .tag(tag), .lookup(lookup),
		.fill_we(fill_we), .fill_word(fill_word), .fill_way(fill_way),
		.write_we(write_we), .write_be(write_be), .write_data(write_data),
		.commit(commit), .touch(touch), .touch_way(touch_way),
		.rd_addr(rd_addr), .inval_set(inval_set),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way), .rd_data(rd_data)
	);

	ddram_port u_ddram_port (
		.CLK(CLK), .rst(rst), .cmd(u_cmd_if),
		.DDRAM_DOUT(DDRAM_DOUT), .DDRAM_DOUT_READY(DDRAM_DOUT_READY),
		.DDRAM_BUSY(DDRAM_BUSY),
		.DDRAM_ADDR(DDRAM_ADDR), .DDRAM_DIN(DDRAM_DIN), .DDRAM_BE(DDRAM_BE),
		.DDRAM_BURSTCNT(DDRAM_BURSTCNT), .DDRAM_RD(DDRAM_RD), .DDRAM_WE(DDRAM_WE)
	);

endmodule

// File: bench/ddr_model.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

module ddr_model (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [`L2_ADDRBITS:0] DDRAM_ADDR,
	input  logic [63:0]           DDRAM_DIN,
	input  logic [7:0]            DDRAM_BE,
	input  logic [7:0]            DDRAM_BURSTCNT,
	input  logic                  DDRAM_RD,
	input  logic                  DDRAM_WE,
	output logic [63:0]           DDRAM_DOUT,
	output logic                  DDRAM_DOUT_READY,
	output logic                  DDRAM_BUSY
);
	logic [63:0]           mem [int];   // only written words live here
	int                    rd_count = 0;
	int                    wr_count = 0;
	logic [`L2_ADDRBITS:0] wr_addr;
	logic [63:0]           wr_din;
	logic [7:0]            wr_be;
	logic [7:0]            wr_burst;
	logic [`L2_ADDRBITS:0] rd_cmd_addr;
	logic [7:0]            rd_cmd_burst;
	logic [`L2_ADDRBITS:0] rd_ptr;
	logic [31:0]           rng;
	int                    beats_left;
	int                    wait_cnt;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// unwritten words follow the address pattern
	function automatic logic [63:0] fetch_word(input logic [`L2_ADDRBITS:0] a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		return {7'h3c, a, 7'h52, a};
	endfunction

	always @(posedge CLK) begin
		logic [63:0] w;
		DDRAM_DOUT_READY <= 1'b0;
		if (rst) begin
			DDRAM_BUSY <= 1'b0;
			DDRAM_DOUT <= '0;
			rd_count = 0;
			wr_count = 0;
			rng = 32'hc941_d42e;
			beats_left = 0;
			wait_cnt = 0;
		end else if (beats_left > 0) begin
			if (wait_cnt > 0)
				wait_cnt--;   // random first-beat latency
			else begin
				DDRAM_DOUT       <= fetch_word(rd_ptr);
				DDRAM_DOUT_READY <= 1'b1;
				rd_ptr = rd_ptr + 1'b1;
				beats_left--;
				if (beats_left == 0)
					DDRAM_BUSY <= 1'b0;
			end
		end else if (!DDRAM_BUSY && DDRAM_RD) begin
			rd_count++;
			rd_ptr = DDRAM_ADDR;
			rd_cmd_addr  = DDRAM_ADDR;
			rd_cmd_burst = DDRAM_BURSTCNT;
			beats_left = int'(DDRAM_BURSTCNT);
			rng = xorshift32(rng);
			wait_cnt = int'(rng[2:0]);
			DDRAM_BUSY <= 1'b1;
		end else if (!DDRAM_BUSY && DDRAM_WE) begin
			wr_count++;
			w = fetch_word(DDRAM_ADDR);
			for (int b = 0; b < 8; b++)
				if (DDRAM_BE[b])
					w[b*8 +: 8] = DDRAM_DIN[b*8 +: 8];
			mem[int'(DDRAM_ADDR)] = w;
			wr_addr  = DDRAM_ADDR;
			wr_din   = DDRAM_DIN;
			wr_be    = DDRAM_BE;
			wr_burst = DDRAM_BURSTCNT;
		end
	end

endmodule

// File: bench/tb_l2_subsys.sv
`timescale 1ns/100ps
`include "l2_cache_defines.svh"

module tb_l2_subsys;

	logic                  CLK;
	logic                  rst;
	logic                  DISABLE;
	logic [29:0]           CPU_ADDR;
	logic [31:0]           CPU_DIN;
	logic [31:0]           CPU_DOUT;
	logic                  CPU_DOUT_READY;
	logic [3:0]            CPU_BE;
	logic [3:0]            CPU_BURSTCNT;
	logic                  CPU_BUSY;
	logic                  CPU_RD;
	logic                  CPU_WE;
	logic [`L2_ADDRBITS:0] DDRAM_ADDR;
	logic [63:0]           DDRAM_DIN;
	logic [63:0]           DDRAM_DOUT;
	logic                  DDRAM_DOUT_READY;
	logic [7:0]            DDRAM_BE;
	logic [7:0]            DDRAM_BURSTCNT;
	logic                  DDRAM_BUSY;
	logic                  DDRAM_RD;
	logic                  DDRAM_WE;

	int          errors;
	int          checks;
	int          tests;
	int          test_errs;
	int          cur_test;
	int          test_id;
	int          fd;
	int          rc;
	int          dcount;
	int          rd0;
	int          wr0;
	logic [7:0]  op;
	logic [31:0] addr;
	logic [31:0] data;
	logic [31:0] be;
	logic [31:0] burst;
	logic [31:0] dis;
	logic [31:0] exp_w [4];
	string       line;
	bit          aborted;

	always #4 CLK = ~CLK;

	l2_subsys_top u_l2_subsys_top (.*);

	ddr_model u_ddr_model (
		.CLK(CLK), .rst(rst),
		.DDRAM_ADDR(DDRAM_ADDR), .DDRAM_DIN(DDRAM_DIN), .DDRAM_BE(DDRAM_BE),
		.DDRAM_BURSTCNT(DDRAM_BURSTCNT), .DDRAM_RD(DDRAM_RD), .DDRAM_WE(DDRAM_WE),
		.DDRAM_DOUT(DDRAM_DOUT), .DDRAM_DOUT_READY(DDRAM_DOUT_READY),
		.DDRAM_BUSY(DDRAM_BUSY)
	);

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic wait_idle(input int limit);
		int k;
		if (aborted)
			return;
		k = 0;
		@(negedge CLK);
		while (CPU_BUSY && k < limit) begin
			@(negedge CLK);
			k++;
		end
		if (CPU_BUSY) begin
			$display("timeout: CPU_BUSY stayed high for %0d cycles", limit);
			aborted = 1;
		end
	endtask

	task automatic wait_ready(input int limit);
		int k;
		k = 0;
		@(negedge CLK);
		while (!CPU_DOUT_READY && k < limit) begin
			@(negedge CLK);
			k++;
		end
		if (!CPU_DOUT_READY) begin
			$display("timeout: no CPU_DOUT_READY within %0d cycles", limit);
			aborted = 1;
		end
	endtask

	// one-cycle rd or we strobe, launched just after the edge
	task automatic send_request(input logic wr);
		@(posedge CLK);
		#1;
		CPU_ADDR     = addr[29:0];
		CPU_DIN      = data;
		CPU_BE       = be[3:0];
		CPU_BURSTCNT = burst[3:0];
		DISABLE      = dis[0];
		CPU_RD       = !wr;
		CPU_WE       = wr;
		@(posedge CLK);
		#1;
		CPU_RD = 1'b0;
		CPU_WE = 1'b0;
	endtask

	task automatic run_op();
		logic [7:0]  exp_be;
		logic [31:0] last_addr;
		rd0 = u_ddr_model.rd_count;
		wr0 = u_ddr_model.wr_count;
		wait_idle(300);
		if (aborted)
			return;
		send_request(op == "W");
		if (op == "R") begin
			for (int i = 0; i < int'(burst); i++) begin
				wait_ready(300);
				if (aborted)
					return;
				if (i < 4)
					check_value($sformatf("CPU_DOUT[%0d]", i), 64'(CPU_DOUT), 64'(exp_w[i]));
			end
		end
		wait_idle(300);
		repeat (4) @(negedge CLK);   // window for a late ddr strobe
		if (op == "R") begin
			check_value("ddr read count delta", 64'(u_ddr_model.rd_count - rd0), 64'(dcount));
			if (dcount != 0) begin
				// last fill is the line of the last word read
				last_addr = addr + burst - 1;
				check_value("DDRAM_ADDR", 64'(u_ddr_model.rd_cmd_addr),
					64'({last_addr[25:4], 3'b000}));
				check_value("DDRAM_BURSTCNT", 64'(u_ddr_model.rd_cmd_burst),
					64'(`L2_LINEWORDS));
			end
		end else begin
			check_value("ddr write count delta", 64'(u_ddr_model.wr_count - wr0), 64'(dcount));
			if (dcount != 0) begin
				exp_be = addr[0] ? {be[3:0], 4'h0} : {4'h0, be[3:0]};
				check_value("DDRAM_ADDR", 64'(u_ddr_model.wr_addr), 64'(addr[25:1]));
				check_value("DDRAM_DIN", u_ddr_model.wr_din, {data, data});
				check_value("DDRAM_BE", 64'(u_ddr_model.wr_be), 64'(exp_be));
				check_value("DDRAM_BURSTCNT", 64'(u_ddr_model.wr_burst), 64'd1);
			end
		end
	endtask

	task automatic report_test();
		tests++;
		$display("test %0d: %s, %0d errors", cur_test,
			(errors == test_errs) ? "ok" : "mismatches", errors - test_errs);
	endtask

	initial begin
		CLK          = 1'b0;
		rst          = 1'b1;
		DISABLE      = 1'b0;
		CPU_ADDR     = '0;
		CPU_DIN      = '0;
		CPU_BE       = '0;
		CPU_BURSTCNT = '0;
		CPU_RD       = 1'b0;
		CPU_WE       = 1'b0;
		errors   = 0;
		checks   = 0;
		tests    = 0;
		aborted  = 0;
		cur_test = -1;
		repeat (10) @(posedge CLK);
		#1 rst = 1'b0;
		wait_idle(300);   // init sweep
		fd = $fopen("bench/l2_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/l2_stimulus.txt");
			aborted = 1;
		end
		while (!aborted && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			rc = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h %h", test_id, op, addr,
				data, be, burst, dis, exp_w[0], exp_w[1], exp_w[2], exp_w[3], dcount);
			if (rc != 12) begin
				$display("malformed stimulus line: %s", line);
				errors++;
				continue;
			end
			if (test_id != cur_test) begin
				if (cur_test >= 0)
					report_test();
				cur_test  = test_id;
				test_errs = errors;
			end
			run_op();
		end
		if (cur_test >= 0 && !aborted)
			report_test();
		if (fd != 0)
			$fclose(fd);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !aborted)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: bench/l2_stimulus.txt
# test op addr data be burst disable exp0 exp1 exp2 exp3 ddr_delta
# addr is a cpu word address, ddr_delta counts ddr reads for R and ddr writes for W
1 R 00000100 00000000 0 1 0 a4000080 00000000 00000000 00000000 1
1 R 00000100 00000000 0 1 0 a4000080 00000000 00000000 00000000 0
2 R 00000201 00000000 0 4 0 78000100 a4000101 78000101 a4000102 1
2 R 0000020e 00000000 0 4 0 a4000107 78000107 a4000108 78000108 1
2 R 00000202 00000000 0 2 0 a4000101 78000101 00000000 00000000 0
3 R 00000300 00000000 0 1 0 a4000180 00000000 00000000 00000000 1
3 W 00000300 11223344 5 1 0 00000000 00000000 00000000 00000000 1
3 R 00000300 00000000 0 1 0 a4220144 00000000 00000000 00000000 0
3 W 00000301 aabbccdd 8 1 0 00000000 00000000 00000000 00000000 1
3 R 00000301 00000000 0 1 0 aa000180 00000000 00000000 00000000 0
4 R 00000050 00000000 0 1 0 a4000028 00000000 00000000 00000000 1
4 R 00000850 00000000 0 1 0 a4000428 00000000 00000000 00000000 1
4 R 00001050 00000000 0 1 0 a4000828 00000000 00000000 00000000 1
4 R 00001850 00000000 0 1 0 a4000c28 00000000 00000000 00000000 1
4 R 00002050 00000000 0 1 0 a4001028 00000000 00000000 00000000 1
4 R 00000050 00000000 0 1 0 a4000028 00000000 00000000 00000000 1
4 R 00001850 00000000 0 1 0 a4000c28 00000000 00000000 00000000 0
5 R 00000100 00000000 0 1 1 a4000080 00000000 00000000 00000000 1
5 R 00000100 00000000 0 1 1 a4000080 00000000 00000000 00000000 1
5 R 00000300 00000000 0 1 1 a4220144 00000000 00000000 00000000 1
6 W 00030010 deadbeef f 1 0 00000000 00000000 00000000 00000000 0
6 R 00030010 00000000 0 1 0 a4018008 00000000 00000000 00000000 1
6 R 04000020 00000000 0 2 0 00000000 00000000 00000000 00000000 0

// File: build.f
+incdir+rtl
rtl/l2_cache_pkg.sv
rtl/l2_cache_if.sv
rtl/cpu_req_decode.sv
rtl/cache_store.sv
rtl/ddram_port.sv
rtl/l2_cache.sv
rtl/l2_subsys_top.sv
bench/ddr_model.sv
bench/tb_l2_subsys.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the l2 cache testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_l2_subsys -o sim_l2 \
	&& ./obj_dir/sim_l2 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log && exit 0 || exit 1
